/* Makefile */
TOP      = tb_board_shell
FILELIST = board_shell.f

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f $(FILELIST)

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		-f $(FILELIST) -o sim_$(TOP)
	./obj_dir/sim_$(TOP) > sim.log
	cat sim.log
	grep -q "TESTS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

/* board_shell.f */
verilog/shell_pkg.sv
verilog/input_conditioner.sv
verilog/run_control.sv
verilog/view_select.sv
verilog/display_scan.sv
verilog/board_shell.sv
tb/tb_board_shell.sv

/* tb/tb_board_shell.sv */
`timescale 1ns/1ps

module tb_board_shell import shell_pkg::*; ();
    localparam int PERIOD     = 40;
    localparam int DEBOUNCE   = 4;
    localparam int SCAN       = 3;
    localparam int SLOW       = 20;
    localparam int FAST       = 6;
    localparam int HOLD       = DEBOUNCE + 8;
    localparam int SCAN_ROUND = SCAN * DIGITS;
    localparam int VIEW_LEN   = HOLD + SCAN_ROUND;
    localparam int N_VIEWS    = 8;
    localparam int N_FALLBACK = 5;
    localparam int N_STEPS    = 4;
    localparam int BP_CYCLES  = 200;
    localparam int RATE_LEN   = 2 * HOLD + 6 * SLOW + 8 * FAST;
    localparam int STEP_LEN   = (N_STEPS + 2) * 2 * HOLD;
    localparam int TOTAL      = 8 + (N_VIEWS + N_FALLBACK) * VIEW_LEN + RATE_LEN
                                + BP_CYCLES + STEP_LEN;
    localparam logic [WORD_W-1:0] TB_FALLBACK = 32'hABBA_BABA;

    logic              clk = 1'b0;
    logic              nrst;
    buttons_t          buttons;
    logic [VIEW_W-1:0] view;
    cpu_status_t       status;
    logic              step_ready;
    logic [DIGITS-1:0] an;
    logic [SEG_W-1:0]  seg;
    logic              step_valid;
    logic              core_nrst;

    integer seed;
    int     errors;
    int     cycle;
    int     hs_total;
    int     last_hs;
    int     last_gap;
    int     hold_violations;
    logic   hold_prev;

    board_shell #(
        .DEBOUNCE_CYCLES(DEBOUNCE),
        .SCAN_CYCLES    (SCAN),
        .SLOW_CYCLES    (SLOW),
        .FAST_CYCLES    (FAST)
    ) i_dut (
        .clk       (clk),
        .nrst      (nrst),
        .buttons   (buttons),
        .view      (view),
        .status    (status),
        .step_ready(step_ready),
        .an        (an),
        .seg       (seg),
        .step_valid(step_valid),
        .core_nrst (core_nrst)
    );

    always #(PERIOD / 2) clk = ~clk;

    task automatic compare(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
        if (expected !== actual) begin
            errors++;
            $display("FAIL %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    function automatic logic [SEG_W-1:0] seg_code(input logic [DIGIT_W-1:0] nibble);
        case (nibble)
            4'h0: return 7'b1000000;
            4'h1: return 7'b1111001;
            4'h2: return 7'b0100100;
            4'h3: return 7'b0110000;
            4'h4: return 7'b0011001;
            4'h5: return 7'b0010010;
            4'h6: return 7'b0000010;
            4'h7: return 7'b1111000;
            4'h8: return 7'b0000000;
            4'h9: return 7'b0011000;
            4'hA: return 7'b0001000;
            4'hB: return 7'b0000011;
            4'hC: return 7'b1000110;
            4'hD: return 7'b0100001;
            4'hE: return 7'b0000110;
            default: return 7'b0001110;
        endcase
    endfunction

    // Switch i selects word i of the status struct, counted from sp upwards.
    function automatic logic [WORD_W-1:0] shown_word(input logic [VIEW_W-1:0] v,
                                                     input cpu_status_t st);
        logic [5*WORD_W-1:0] flat;
        flat = st;
        if ($onehot(v)) begin
            for (int i = 0; i < VIEW_W; i++) begin
                if (v[i]) begin
                    return flat[i*WORD_W +: WORD_W];
                end
            end
        end
        return TB_FALLBACK;
    endfunction

    function automatic cpu_status_t random_status();
        return {$random(seed), $random(seed), $random(seed), $random(seed), $random(seed)};
    endfunction

    task automatic watch_display(input string name);
        logic [WORD_W-1:0] word;
        logic [DIGITS-1:0] lit;
        int                idx;
        int                last_idx;
        word     = shown_word(view, status);
        lit      = '0;
        last_idx = -1;
        repeat (HOLD) @(negedge clk);
        repeat (SCAN_ROUND) begin
            @(negedge clk);
            idx = 0;
            for (int i = 0; i < DIGITS; i++) begin
                if (!an[i]) begin
                    idx = i;
                end
            end
            // The scan only ever moves on to the next digit up.
            if (last_idx >= 0 && idx != last_idx) begin
                compare({name, "_order"}, (last_idx + 1) % DIGITS, idx);
            end
            last_idx = idx;
            lit      = lit | ~an;
            compare({name, "_an"}, 1, $onehot(~an));
            compare(name, seg_code(word[idx*DIGIT_W +: DIGIT_W]), seg);
        end
        compare({name, "_scan"}, {DIGITS{1'b1}}, lit);
    endtask

    // The first handshake and the first gap of the window are not measured.
    task automatic measure_rate(input string name, input int rate, input int cycles);
        int seen;
        int n_hs;
        int gaps;
        repeat (HOLD) @(negedge clk);
        seen = hs_total;
        n_hs = 0;
        gaps = 0;
        repeat (cycles) begin
            @(negedge clk);
            if (hs_total != seen) begin
                seen = hs_total;
                n_hs++;
                if (n_hs >= 3) begin
                    compare(name, rate, last_gap);
                    gaps++;
                end
            end
        end
        compare({name, "_gaps"}, 1, gaps >= 3);
    endtask

    always @(posedge clk) begin
        if (hold_prev && !step_valid) begin
            hold_violations++;
            $display("ERROR: step_valid dropped at cycle %0d without a handshake", cycle);
        end
        hold_prev = step_valid && !step_ready;
        if (step_valid && step_ready) begin
            last_gap = cycle - last_hs;
            last_hs  = cycle;
            hs_total++;
        end
        cycle++;
    end

    initial begin
        #(TOTAL * 2 * PERIOD);
        $display("ERROR: simulation timed out after %0d cycles", TOTAL * 2);
        $display("TESTS FAILED");
        $finish;
    end

    initial begin
        int                seen;
        logic [VIEW_W-1:0] v;
        nrst            = 1'b0;
        buttons         = '0;
        view            = '0;
        status          = '0;
        step_ready      = 1'b0;
        seed            = 96;
        errors          = 0;
        cycle           = 0;
        hs_total        = 0;
        last_hs         = 0;
        last_gap        = 0;
        hold_violations = 0;
        hold_prev       = 1'b0;
        status          = random_status();

        repeat (3) begin
            @(negedge clk);
            compare("reset_valid", 0, step_valid);
            compare("reset_an", 8'hFE, an);
            compare("reset_seg", seg_code(TB_FALLBACK[3:0]), seg);
        end
        nrst       = 1'b1;
        step_ready = 1'b1;
        @(negedge clk);
        compare("reset_sync", 0, core_nrst);
        @(negedge clk);
        compare("reset_release", 1, core_nrst);
        compare("reset_done_valid", 0, step_valid);
        compare("reset_done_an", 8'hFE, an);

        for (int n = 0; n < N_VIEWS; n++) begin
            status = random_status();
            view   = VIEW_W'(1) << ($unsigned($random(seed)) % VIEW_W);
            watch_display("view");
        end

        view = '0;
        watch_display("fallback_zero");
        for (int n = 1; n < N_FALLBACK; n++) begin
            do begin
                v = VIEW_W'($random(seed));
            end while ($countones(v) < 2);
            view = v;
            watch_display("fallback_multi");
        end

        measure_rate("rate_slow", SLOW, 6 * SLOW);
        buttons.turbo = 1'b1;
        measure_rate("rate_fast", FAST, 8 * FAST);

        // One request may already be pending when this phase starts.
        seen = hs_total;
        repeat (BP_CYCLES) begin
            @(negedge clk);
            step_ready = 1'($random(seed) & 1);
        end
        step_ready = 1'b1;
        compare("backpressure_ticks", 1, hs_total - seen <= BP_CYCLES / FAST + 2);
        compare("backpressure_progress", 1, hs_total - seen > 0);

        buttons.turbo = 1'b0;
        buttons.stall = 1'b1;
        repeat (2 * HOLD) @(negedge clk);
        for (int n = 0; n < N_STEPS; n++) begin
            seen         = hs_total;
            buttons.step = 1'b1;
            repeat (HOLD) @(negedge clk);
            buttons.step = 1'b0;
            repeat (HOLD) @(negedge clk);
            compare("step_press", 1, hs_total - seen);
        end
        seen         = hs_total;
        buttons.step = 1'b1;
        repeat (DEBOUNCE - 2) @(negedge clk);
        buttons.step = 1'b0;
        repeat (2 * HOLD) @(negedge clk);
        compare("step_glitch", 0, hs_total - seen);

        compare("valid_hold", 0, hold_violations);
        $display("Handshakes: %0d, errors: %0d", hs_total, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

/* verilog/board_shell.sv */
`timescale 1ns/1ps

module board_shell import shell_pkg::*; #(
    parameter int unsigned DEBOUNCE_CYCLES = DEBOUNCE_DEFAULT,
    parameter int unsigned SCAN_CYCLES     = SCAN_DEFAULT,
    parameter int unsigned SLOW_CYCLES     = SLOW_DEFAULT,
    parameter int unsigned FAST_CYCLES     = FAST_DEFAULT
) (
    input  logic              clk,
    input  logic              nrst,
    input  buttons_t          buttons,
    input  logic [VIEW_W-1:0] view,
    input  cpu_status_t       status,
    input  logic              step_ready,
    output logic [DIGITS-1:0] an,
    output logic [SEG_W-1:0]  seg,
    output logic              step_valid,
    output logic              core_nrst
);
    buttons_t          clean_buttons;
    logic [VIEW_W-1:0] clean_view;
    display_word_t     shown;

    // The synchronized reset goes to the core and to every block of the shell.
    input_conditioner #(
        .DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)
    ) i_input_conditioner (
        .clk          (clk),
        .nrst         (nrst),
        .buttons      (buttons),
        .view         (view),
        .sys_nrst     (core_nrst),
        .clean_buttons(clean_buttons),
        .clean_view   (clean_view)
    );

    run_control #(
        .SLOW_CYCLES(SLOW_CYCLES),
        .FAST_CYCLES(FAST_CYCLES)
    ) i_run_control (
        .clk          (clk),
        .nrst         (core_nrst),
        .clean_buttons(clean_buttons),
        .step_ready   (step_ready),
        .step_valid   (step_valid)
    );

    view_select i_view_select (
        .clk       (clk),
        .nrst      (core_nrst),
        .clean_view(clean_view),
        .status    (status),
        .shown     (shown)
    );

    display_scan #(
        .SCAN_CYCLES(SCAN_CYCLES)
    ) i_display_scan (
        .clk  (clk),
        .nrst (core_nrst),
        .shown(shown),
        .an   (an),
        .seg  (seg)
    );

endmodule

/* verilog/display_scan.sv */
`timescale 1ns/1ps

module display_scan import shell_pkg::*; #(
    parameter int unsigned SCAN_CYCLES = SCAN_DEFAULT
) (
    input  logic              clk,
    input  logic              nrst,
    input  display_word_t     shown,
    output logic [DIGITS-1:0] an,
    output logic [SEG_W-1:0]  seg
);
    logic [CNT_W-1:0]          scan_count;
    logic [$clog2(DIGITS)-1:0] digit_idx;

    // The index wraps from the last digit back to digit 0 on its own.
    always_ff @(posedge clk, negedge nrst) begin
        if (!nrst) begin
            scan_count <= '0;
            digit_idx  <= '0;
        end else if (scan_count == CNT_W'(SCAN_CYCLES - 1)) begin
            scan_count <= '0;
            digit_idx  <= digit_idx + 1'b1;
        end else begin
            scan_count <= scan_count + CNT_W'(1);
        end
    end

    // Anodes are active low.
    assign an = ~(DIGITS'(1) << digit_idx);

    assign seg = seg_table[shown.digits[digit_idx]];

    // Two lit digits at once would smear the display.
    assert property (@(posedge clk) disable iff (!nrst)
        $onehot(~an))
        else $error("more or less than one digit enabled, an=%b", an);

endmodule

/* verilog/input_conditioner.sv */
`timescale 1ns/1ps

module input_conditioner import shell_pkg::*; #(
    parameter int unsigned DEBOUNCE_CYCLES = DEBOUNCE_DEFAULT
) (
    input  logic              clk,
    input  logic              nrst,
    input  buttons_t          buttons,
    input  logic [VIEW_W-1:0] view,
    output logic              sys_nrst,
    output buttons_t          clean_buttons,
    output logic [VIEW_W-1:0] clean_view
);
    logic                               rst_meta;
    logic [VIEW_W+$bits(buttons_t)-1:0] raw;
    logic [VIEW_W+$bits(buttons_t)-1:0] sync_0;
    logic [VIEW_W+$bits(buttons_t)-1:0] sync_1;
    logic [VIEW_W+$bits(buttons_t)-1:0] prev;
    logic [VIEW_W+$bits(buttons_t)-1:0] clean;
    logic [CNT_W-1:0]                   count [VIEW_W+$bits(buttons_t)];

    // Reset asserts at once and is released two clock edges after nrst rises.
    always_ff @(posedge clk, negedge nrst) begin
        if (!nrst) begin
            rst_meta <= 1'b0;
            sys_nrst <= 1'b0;
        end else begin
            rst_meta <= 1'b1;
            sys_nrst <= rst_meta;
        end
    end

    assign raw = {view, buttons};

    always_ff @(posedge clk, negedge sys_nrst) begin
        if (!sys_nrst) begin
            sync_0 <= '0;
            sync_1 <= '0;
            prev   <= '0;
        end else begin
            sync_0 <= raw;
            sync_1 <= sync_0;
            prev   <= sync_1;
        end
    end

    // A level is accepted only after it has been stable for the full count.
    always_ff @(posedge clk, negedge sys_nrst) begin
        if (!sys_nrst) begin
            for (int i = 0; i < $bits(raw); i++) begin
                count[i] <= '0;
            end
            clean <= '0;
        end else begin
            for (int i = 0; i < $bits(raw); i++) begin
                if (sync_1[i] != prev[i]) begin
                    count[i] <= '0;
                end else if (count[i] != CNT_W'(DEBOUNCE_CYCLES)) begin
                    count[i] <= count[i] + CNT_W'(1);
                end else begin
                    clean[i] <= sync_1[i];
                end
            end
        end
    end

    assign {clean_view, clean_buttons} = clean;

endmodule

/* verilog/run_control.sv */
`timescale 1ns/1ps

module run_control import shell_pkg::*; #(
    parameter int unsigned SLOW_CYCLES = SLOW_DEFAULT,
    parameter int unsigned FAST_CYCLES = FAST_DEFAULT
) (
    input  logic     clk,
    input  logic     nrst,
    input  buttons_t clean_buttons,
    input  logic     step_ready,
    output logic     step_valid
);
    logic [CNT_W-1:0] rate_count;
    logic [CNT_W-1:0] rate_last;
    logic             turbo_prev;
    logic             turbo_changed;
    logic             step_prev;
    logic             tick;
    logic             step_edge;
    logic             request;
    logic             handshake;

    assign rate_last = clean_buttons.turbo ? CNT_W'(FAST_CYCLES - 1)
                                           : CNT_W'(SLOW_CYCLES - 1);

    assign turbo_changed = clean_buttons.turbo != turbo_prev;
    assign tick          = !turbo_changed && (rate_count == rate_last);
    assign step_edge     = clean_buttons.step && !step_prev;

    // While stalled only a step press asks for a step, the rate ticks are ignored.
    assign request   = clean_buttons.stall ? step_edge : tick;
    assign handshake = step_valid && step_ready;

    always_ff @(posedge clk, negedge nrst) begin
        if (!nrst) begin
            rate_count <= '0;
            turbo_prev <= 1'b0;
            step_prev  <= 1'b0;
        end else begin
            turbo_prev <= clean_buttons.turbo;
            step_prev  <= clean_buttons.step;
            if (turbo_changed || rate_count == rate_last) begin
                rate_count <= '0;
            end else begin
                rate_count <= rate_count + CNT_W'(1);
            end
        end
    end

    // A request seen while one is still pending is lost.
    always_ff @(posedge clk, negedge nrst) begin
        if (!nrst) begin
            step_valid <= 1'b0;
        end else if (handshake) begin
            step_valid <= 1'b0;
        end else if (request) begin
            step_valid <= 1'b1;
        end
    end

    // The core may hold off a step for any time; the request must wait for it.
    assert property (@(posedge clk) disable iff (!nrst)
        step_valid && !step_ready |=> step_valid)
        else $error("step_valid fell without a handshake");

endmodule

/* verilog/shell_pkg.sv */
package shell_pkg;

    localparam int WORD_W  = 32;
    localparam int DIGIT_W = 4;
    localparam int DIGITS  = 8;
    localparam int SEG_W   = 7;
    localparam int VIEW_W  = 5;

    // Width of the debounce, rate and scan counters.
    localparam int CNT_W = 32;

    localparam int unsigned DEBOUNCE_DEFAULT = 5_000_000;
    localparam int unsigned SCAN_DEFAULT     = 5_000;
    localparam int unsigned SLOW_DEFAULT     = 25_000_000;
    localparam int unsigned FAST_DEFAULT     = 100_000;

    localparam logic [WORD_W-1:0] FALLBACK_WORD = 32'hABBA_BABA;

    // Active-low segment codes, bit 6 is segment g and bit 0 is segment a.
    localparam logic [SEG_W-1:0] seg_table [16] = '{
        7'b1000000, 7'b1111001, 7'b0100100, 7'b0110000,
        7'b0011001, 7'b0010010, 7'b0000010, 7'b1111000,
        7'b0000000, 7'b0011000, 7'b0001000, 7'b0000011,
        7'b1000110, 7'b0100001, 7'b0000110, 7'b0001110
    };

    typedef struct packed {
        logic [WORD_W-1:0] pc_wb;
        logic [WORD_W-1:0] array_view;
        logic [WORD_W-1:0] ra;
        logic [WORD_W-1:0] s8;
        logic [WORD_W-1:0] sp;
    } cpu_status_t;

    // Digit 0 is the least significant nibble.
    typedef union packed {
        logic [WORD_W-1:0]              value;
        logic [DIGITS-1:0][DIGIT_W-1:0] digits;
    } display_word_t;

    typedef struct packed {
        logic stall;
        logic step;
        logic turbo;
    } buttons_t;

endpackage

/* verilog/view_select.sv */
`timescale 1ns/1ps

module view_select import shell_pkg::*; (
    input  logic              clk,
    input  logic              nrst,
    input  logic [VIEW_W-1:0] clean_view,
    input  cpu_status_t       status,
    output display_word_t     shown
);
    logic [VIEW_W-1:0] view_cfg;

    always_ff @(posedge clk, negedge nrst) begin
        if (!nrst) begin
            view_cfg <= '0;
        end else begin
            view_cfg <= clean_view;
        end
    end

    // Exactly one switch must be up, anything else shows the fallback pattern.
    always_comb begin
        case (view_cfg)
            5'b10000: begin
                shown.value = status.pc_wb;
            end
            5'b01000: begin
                shown.value = status.array_view;
            end
            5'b00100: begin
                shown.value = status.ra;
            end
            5'b00010: begin
                shown.value = status.s8;
            end
            5'b00001: begin
                shown.value = status.sp;
            end
            default: begin
                shown.value = FALLBACK_WORD;
            end
        endcase
    end

endmodule
